// ==== motorPwm_defs.svh ====
`ifndef MOTOR_PWM_DEFS_SVH
`define MOTOR_PWM_DEFS_SVH

// demand sums, pulse counters and loss values
`define POS_W 16
// pwm period length and amplitude
`define LEN_W 12
// cycle counter inside one step
`define CNT_W 15
// step number
`define STEP_W 4

// twelve steps make one electrical cycle
`define STEP_COUNT 12
// shortest pulse the MOSFET driver can follow, in clk cycles
`define PWM_MIN 32
`define PHASE_COUNT 3
// step distance between neighbouring phases
`define PHASE_OFFSET 4

`endif

// ==== motorStepPkg.sv ====
package motorStepPkg;

    // sequencer state
    // idle keeps the step counter parked at zero
    typedef enum logic [0:0] {
        SEQ_IDLE,
        SEQ_RUN
    } seqStateT;

    // phase identifiers, also used as array index
    // for the per-phase wires at the top level
    typedef enum logic [1:0] {
        PHASE_A,
        PHASE_B,
        PHASE_C
    } phaseIdT;

endpackage

// ==== pwmLoadPkg.sv ====
package pwmLoadPkg;

    // what happens to the carried-over demand register
    typedef enum logic [1:0] {
        REMAIN_HOLD,
        REMAIN_ADD,
        REMAIN_ZERO
    } remainLoadT;

    // what happens to the pulse length counter
    typedef enum logic [1:0] {
        PULSE_HOLD,
        PULSE_DEC,
        PULSE_LOAD,
        PULSE_ZERO
    } pulseLoadT;

    // remainder and pulse opcodes are decoded together
    // once per cycle inside each phase generator
    // a load always overrides a decrement in flight

endpackage

// ==== stepSequencer.sv ====
`include "motorPwm_defs.svh"

module stepSequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               run,
    input  logic [`LEN_W-1:0]  pwmLenWant,
    input  logic [1:0]         stepSplitMax,
    output logic [`STEP_W-1:0] sgStep,
    output logic               pwmActive,
    output logic               cntFirst1,
    output logic               cntFirst2,
    output logic               cntLast2,
    output logic               cntLast1
);
    import motorStepPkg::*;

    seqStateT           state;
    logic [`CNT_W-1:0]  cnt;
    logic [`CNT_W-1:0]  stepLen;
    logic [`CNT_W-1:0]  stepEnd;
    logic               running;

    // step length is the pwm period times 1, 2, 4 or 8
    assign stepLen = {{(`CNT_W - `LEN_W){1'b0}}, pwmLenWant} << stepSplitMax;
    assign stepEnd = stepLen - `CNT_W'(1);

    assign running   = (state == SEQ_RUN);
    assign pwmActive = running;

    // step boundary strobes, only while running
    assign cntFirst1 = running && (cnt == `CNT_W'(0));
    assign cntFirst2 = running && (cnt == `CNT_W'(1));
    assign cntLast2  = running && (cnt == stepLen - `CNT_W'(2));
    assign cntLast1  = running && (cnt == stepEnd);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= SEQ_IDLE;
            cnt    <= '0;
            sgStep <= '0;
        end else if (!run) begin
            // stopping always restarts from step 0
            state  <= SEQ_IDLE;
            cnt    <= '0;
            sgStep <= '0;
        end else if (state == SEQ_IDLE) begin
            state <= SEQ_RUN;
            cnt   <= '0;
        end else begin
            if (cnt == stepEnd) begin
                cnt <= '0;
                // wrap after the last step of the electrical cycle
                if (sgStep == `STEP_W'(`STEP_COUNT - 1)) begin
                    sgStep <= '0;
                end else begin
                    sgStep <= sgStep + `STEP_W'(1);
                end
            end else begin
                cnt <= cnt + `CNT_W'(1);
            end
        end
    end

endmodule

// ==== phaseLenTable.sv ====
`include "motorPwm_defs.svh"

module phaseLenTable (
    input  logic [`STEP_W-1:0] sgStep,
    input  logic [`LEN_W-1:0]  amplitude,
    output logic [`POS_W-1:0]  lenPosA,
    output logic [`POS_W-1:0]  lenPosB,
    output logic [`POS_W-1:0]  lenPosC
);
    import motorStepPkg::*;

    // trapezoid: ramp up over 4 steps, flat for 3, ramp down, 2 off
    function automatic logic [2:0] weightAt(input int idx);
        case (idx)
            1, 9:    weightAt = 3'd1;
            2, 8:    weightAt = 3'd2;
            3, 7:    weightAt = 3'd3;
            4, 5, 6: weightAt = 3'd4;
            default: weightAt = 3'd0;
        endcase
    endfunction

    function automatic logic [`POS_W-1:0] phaseDemand(input phaseIdT phase);
        int                idx;
        logic [`LEN_W+2:0] product;
        idx = int'(sgStep) + `PHASE_OFFSET * int'(phase);
        // sgStep never exceeds 11, so one subtraction is enough
        if (idx >= `STEP_COUNT) begin
            idx = idx - `STEP_COUNT;
        end
        product = amplitude * weightAt(idx);
        // full weight 4 gives back the plain amplitude
        phaseDemand = `POS_W'(product >> 2);
    endfunction

    assign lenPosA = phaseDemand(PHASE_A);
    assign lenPosB = phaseDemand(PHASE_B);
    assign lenPosC = phaseDemand(PHASE_C);

endmodule

// ==== pwmPhaseGen.sv ====
`include "motorPwm_defs.svh"

module pwmPhaseGen (
    input  logic              clk,
    input  logic              reset,
    input  logic              pwmActive,
    input  logic [`POS_W-1:0] lenPos,
    input  logic [`LEN_W-1:0] pwmLenWant,
    input  logic              cntFirst1,
    input  logic              cntLast2,
    input  logic              cntLast1,
    output logic              pwm,
    output logic [`POS_W-1:0] posLost
);
    import pwmLoadPkg::*;

    logic [`LEN_W-1:0] periodCnt;
    logic              periodEnd;

    logic [`POS_W-1:0] remain;
    logic [`POS_W-1:0] pulseCnt;
    logic [`POS_W-1:0] sum;
    logic              reachMin;

    remainLoadT        remainOp;
    pulseLoadT         pulseOp;

    logic [`POS_W-1:0] wantAcc;
    logic [`POS_W-1:0] realAcc;

    // pwm period counter, counts down to 1 and reloads
    // also realigned to the step grid on cntLast1
    always_ff @(posedge clk) begin
        if (reset) begin
            periodCnt <= pwmLenWant;
        end else if (!pwmActive || cntLast1 || periodCnt == `LEN_W'(1)) begin
            periodCnt <= pwmLenWant;
        end else begin
            periodCnt <= periodCnt - `LEN_W'(1);
        end
    end

    assign periodEnd = pwmActive && (periodCnt == `LEN_W'(1));

    // demand carried so far plus this period's share
    assign sum      = remain + lenPos;
    assign reachMin = (sum >= `POS_W'(`PWM_MIN));

    always_comb begin
        remainOp = REMAIN_HOLD;
        pulseOp  = PULSE_HOLD;
        if (pulseCnt != '0) begin
            pulseOp = PULSE_DEC;
        end
        if (periodEnd) begin
            if (reachMin) begin
                // fire now, this may cut short a pulse still running
                pulseOp  = PULSE_LOAD;
                remainOp = REMAIN_ZERO;
            end else begin
                // too short for the driver, carry it over
                remainOp = REMAIN_ADD;
            end
        end
        if (!pwmActive) begin
            pulseOp  = PULSE_ZERO;
            remainOp = REMAIN_ZERO;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            remain <= '0;
        end else begin
            case (remainOp)
                REMAIN_ADD:  remain <= sum;
                REMAIN_ZERO: remain <= '0;
                default:     remain <= remain;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pulseCnt <= '0;
        end else begin
            case (pulseOp)
                PULSE_DEC:  pulseCnt <= pulseCnt - `POS_W'(1);
                PULSE_LOAD: pulseCnt <= sum;
                PULSE_ZERO: pulseCnt <= '0;
                default:    pulseCnt <= pulseCnt;
            endcase
        end
    end

    assign pwm = (pulseCnt != '0);

    // per-step bookkeeping of wanted versus delivered high time
    always_ff @(posedge clk) begin
        if (reset) begin
            wantAcc <= '0;
            realAcc <= '0;
        end else if (cntFirst1) begin
            wantAcc <= '0;
            realAcc <= '0;
        end else begin
            if (periodEnd) begin
                wantAcc <= wantAcc + lenPos;
            end
            if (pwm) begin
                realAcc <= realAcc + `POS_W'(1);
            end
        end
    end

    // loss is sampled one cycle before the step ends
    always_ff @(posedge clk) begin
        if (reset) begin
            posLost <= '0;
        end else if (cntLast2) begin
            if (wantAcc >= realAcc) begin
                posLost <= wantAcc - realAcc;
            end else begin
                posLost <= realAcc - wantAcc;
            end
        end
    end

endmodule

// ==== motorPwmTop.sv ====
`include "motorPwm_defs.svh"

module motorPwmTop (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    run,
    input  logic [`LEN_W-1:0]       pwmLenWant,
    input  logic [1:0]              stepSplitMax,
    input  logic [`LEN_W-1:0]       amplitude,
    output logic [`PHASE_COUNT-1:0] pwm,
    output logic [`POS_W-1:0]       posLostA,
    output logic [`POS_W-1:0]       posLostB,
    output logic [`POS_W-1:0]       posLostC,
    output logic [`STEP_W-1:0]      sgStep,
    output logic                    pwmActive
);
    import motorStepPkg::*;

    logic              cntFirst1;
    logic              cntLast2;
    logic              cntLast1;

    // per-phase demand indexed by phase id
    logic [`POS_W-1:0] lenPos [`PHASE_COUNT];

    stepSequencer stepSequencer_i (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .pwmLenWant   (pwmLenWant),
        .stepSplitMax (stepSplitMax),
        .sgStep       (sgStep),
        .pwmActive    (pwmActive),
        .cntFirst1    (cntFirst1),
        .cntFirst2    (),
        .cntLast2     (cntLast2),
        .cntLast1     (cntLast1)
    );

    phaseLenTable phaseLenTable_i (
        .sgStep    (sgStep),
        .amplitude (amplitude),
        .lenPosA   (lenPos[PHASE_A]),
        .lenPosB   (lenPos[PHASE_B]),
        .lenPosC   (lenPos[PHASE_C])
    );

    pwmPhaseGen phaseGenA (
        .clk (clk), .reset (reset), .pwmActive (pwmActive),
        .lenPos (lenPos[PHASE_A]), .pwmLenWant (pwmLenWant),
        .cntFirst1 (cntFirst1), .cntLast2 (cntLast2), .cntLast1 (cntLast1),
        .pwm (pwm[PHASE_A]), .posLost (posLostA)
    );

    pwmPhaseGen phaseGenB (
        .clk (clk), .reset (reset), .pwmActive (pwmActive),
        .lenPos (lenPos[PHASE_B]), .pwmLenWant (pwmLenWant),
        .cntFirst1 (cntFirst1), .cntLast2 (cntLast2), .cntLast1 (cntLast1),
        .pwm (pwm[PHASE_B]), .posLost (posLostB)
    );

    pwmPhaseGen phaseGenC (
        .clk (clk), .reset (reset), .pwmActive (pwmActive),
        .lenPos (lenPos[PHASE_C]), .pwmLenWant (pwmLenWant),
        .cntFirst1 (cntFirst1), .cntLast2 (cntLast2), .cntLast1 (cntLast1),
        .pwm (pwm[PHASE_C]), .posLost (posLostC)
    );

endmodule

// ==== motorPwm_props.sv ====
`include "motorPwm_defs.svh"

module motorPwm_props (
    input logic                    clk,
    input logic                    reset,
    input logic [`STEP_W-1:0]      sgStep,
    input logic                    pwmActive,
    input logic [`PHASE_COUNT-1:0] pwm
);

    function automatic logic [`STEP_W-1:0] nextStep(input logic [`STEP_W-1:0] step);
        if (step == `STEP_W'(`STEP_COUNT - 1)) begin
            return '0;
        end
        return step + `STEP_W'(1);
    endfunction

    // step number stays inside one electrical cycle
    stepInRange: assert property (@(posedge clk) disable iff (reset)
        sgStep < `STEP_W'(`STEP_COUNT))
        else $error("sgStep left the range of one electrical cycle");

    // while running the step only moves forward by one, modulo 12
    stepAdvance: assert property (@(posedge clk) disable iff (reset)
        (pwmActive && $past(pwmActive) && sgStep != $past(sgStep))
        |-> sgStep == nextStep($past(sgStep)))
        else $error("sgStep changed by something other than one step");

    // pulse counters clear on the cycle the sequencer is idle
    pwmOffWhenIdle: assert property (@(posedge clk) disable iff (reset)
        !pwmActive |=> pwm == '0)
        else $error("pwm still high one cycle after pwmActive was low");

endmodule

// ==== motorPwmTb.sv ====
`include "motorPwm_defs.svh"

module motorPwmTb;
    import motorStepPkg::*;
    import pwmLoadPkg::*;

    localparam int RUN_SEGMENTS  = 8;
    localparam int START_TIMEOUT = 16;
    localparam int weightTable [`STEP_COUNT] = '{0, 1, 2, 3, 4, 4, 4, 3, 2, 1, 0, 0};

    logic                    clk;
    logic                    reset;
    logic                    run;
    logic [`LEN_W-1:0]       pwmLenWant;
    logic [1:0]              stepSplitMax;
    logic [`LEN_W-1:0]       amplitude;
    logic [`PHASE_COUNT-1:0] pwm;
    logic [`POS_W-1:0]       posLostA;
    logic [`POS_W-1:0]       posLostB;
    logic [`POS_W-1:0]       posLostC;
    logic [`STEP_W-1:0]      sgStep;
    logic                    pwmActive;

    logic [31:0]             rngState = 32'd63;

    // reference model state follows the DUT edge by edge
    seqStateT                mState;
    logic [`CNT_W-1:0]       mCnt;
    logic [`STEP_W-1:0]      mStep;
    logic [`LEN_W-1:0]       mPeriod [`PHASE_COUNT];
    logic [`POS_W-1:0]       mRemain [`PHASE_COUNT];
    logic [`POS_W-1:0]       mPulse [`PHASE_COUNT];
    logic [`POS_W-1:0]       mWant [`PHASE_COUNT];
    logic [`POS_W-1:0]       mReal [`PHASE_COUNT];
    logic [`POS_W-1:0]       mLost [`PHASE_COUNT];

    motorPwmTop motorPwmTop_i (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .pwmLenWant   (pwmLenWant),
        .stepSplitMax (stepSplitMax),
        .amplitude    (amplitude),
        .pwm          (pwm),
        .posLostA     (posLostA),
        .posLostB     (posLostB),
        .posLostC     (posLostC),
        .sgStep       (sgStep),
        .pwmActive    (pwmActive)
    );

    bind motorPwmTop motorPwm_props motorPwmProps_i (
        .clk (clk), .reset (reset), .sgStep (sgStep), .pwmActive (pwmActive), .pwm (pwm)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int drawBelow(input int bound);
        rngState = xorshift32(rngState);
        return int'(rngState % 32'(bound));
    endfunction

    // trapezoid demand of phase p at the model's current step
    function automatic logic [`POS_W-1:0] demandOf(input int p);
        int idx;
        idx = (int'(mStep) + `PHASE_OFFSET * p) % `STEP_COUNT;
        return `POS_W'((int'(amplitude) * weightTable[idx]) >> 2);
    endfunction

    function automatic logic [`PHASE_COUNT-1:0] modelPwm();
        logic [`PHASE_COUNT-1:0] bits;
        for (int p = 0; p < `PHASE_COUNT; p++) begin
            bits[p] = (mPulse[p] != '0);
        end
        return bits;
    endfunction

    always @(posedge clk) begin : modelStep
        logic [`CNT_W-1:0] stepLen;
        logic              running;
        logic              first1;
        logic              last2;
        logic              last1;
        logic              periodEnd;
        logic [`POS_W-1:0] lenPos;
        logic [`POS_W-1:0] sum;
        pulseLoadT         pulseOp;
        remainLoadT        remainOp;
        if (reset) begin
            mState = SEQ_IDLE;
            mCnt   = '0;
            mStep  = '0;
            for (int p = 0; p < `PHASE_COUNT; p++) begin
                mPeriod[p] = pwmLenWant;
                mRemain[p] = '0;
                mPulse[p]  = '0;
                mWant[p]   = '0;
                mReal[p]   = '0;
                mLost[p]   = '0;
            end
        end else begin
            stepLen = `CNT_W'(pwmLenWant) << stepSplitMax;
            running = (mState == SEQ_RUN);
            first1  = running && (mCnt == '0);
            last2   = running && (mCnt == stepLen - `CNT_W'(2));
            last1   = running && (mCnt == stepLen - `CNT_W'(1));
            for (int p = 0; p < `PHASE_COUNT; p++) begin
                lenPos    = demandOf(p);
                periodEnd = running && (mPeriod[p] == `LEN_W'(1));
                sum       = mRemain[p] + lenPos;
                // loss window closes on the sums from before this edge
                if (last2) begin
                    mLost[p] = (mWant[p] >= mReal[p]) ? mWant[p] - mReal[p]
                                                      : mReal[p] - mWant[p];
                end
                if (first1) begin
                    mWant[p] = '0;
                    mReal[p] = '0;
                end else begin
                    if (periodEnd) mWant[p] = mWant[p] + lenPos;
                    if (mPulse[p] != '0) mReal[p] = mReal[p] + `POS_W'(1);
                end
                pulseOp  = (mPulse[p] != '0) ? PULSE_DEC : PULSE_HOLD;
                remainOp = REMAIN_HOLD;
                if (!running) begin
                    pulseOp  = PULSE_ZERO;
                    remainOp = REMAIN_ZERO;
                end else if (periodEnd && sum >= `POS_W'(`PWM_MIN)) begin
                    pulseOp  = PULSE_LOAD;
                    remainOp = REMAIN_ZERO;
                end else if (periodEnd) begin
                    remainOp = REMAIN_ADD;
                end
                case (pulseOp)
                    PULSE_DEC:  mPulse[p] = mPulse[p] - `POS_W'(1);
                    PULSE_LOAD: mPulse[p] = sum;
                    PULSE_ZERO: mPulse[p] = '0;
                    default:    mPulse[p] = mPulse[p];
                endcase
                case (remainOp)
                    REMAIN_ADD:  mRemain[p] = sum;
                    REMAIN_ZERO: mRemain[p] = '0;
                    default:     mRemain[p] = mRemain[p];
                endcase
                if (!running || last1 || mPeriod[p] == `LEN_W'(1)) begin
                    mPeriod[p] = pwmLenWant;
                end else begin
                    mPeriod[p] = mPeriod[p] - `LEN_W'(1);
                end
            end
            if (!run) begin
                mState = SEQ_IDLE;
                mCnt   = '0;
                mStep  = '0;
            end else if (!running) begin
                mState = SEQ_RUN;
                mCnt   = '0;
            end else if (last1) begin
                mCnt  = '0;
                mStep = (mStep == `STEP_W'(`STEP_COUNT - 1)) ? '0 : mStep + `STEP_W'(1);
            end else begin
                mCnt = mCnt + `CNT_W'(1);
            end
        end
    end

    task automatic stopWithFailure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic reportMismatch(input string what);
        $display("[FAIL] time %0t: %s", $time, what);
        stopWithFailure();
    endtask

    task automatic checkPwm(input logic [`PHASE_COUNT-1:0] got,
                            input logic [`PHASE_COUNT-1:0] exp);
        if (got !== exp) reportMismatch($sformatf("pwm is %b, expected %b", got, exp));
    endtask

    task automatic checkStep(input logic [`STEP_W-1:0] got, input logic [`STEP_W-1:0] exp);
        if (got !== exp) reportMismatch($sformatf("sgStep is %0d, expected %0d", got, exp));
    endtask

    task automatic checkActive(input logic got, input logic exp);
        if (got !== exp) reportMismatch($sformatf("pwmActive is %b, expected %b", got, exp));
    endtask

    task automatic checkLost(input phaseIdT phase, input logic [`POS_W-1:0] got,
                             input logic [`POS_W-1:0] exp);
        if (got !== exp) begin
            reportMismatch($sformatf("posLost of %s is %0d, expected %0d",
                                     phase.name(), got, exp));
        end
    endtask

    // outputs are settled half a cycle after the rising edge
    task automatic tick();
        @(negedge clk);
        checkStep(sgStep, mStep);
        checkActive(pwmActive, mState == SEQ_RUN);
        checkPwm(pwm, modelPwm());
        checkLost(PHASE_A, posLostA, mLost[0]);
        checkLost(PHASE_B, posLostB, mLost[1]);
        checkLost(PHASE_C, posLostC, mLost[2]);
    endtask

    task automatic waitActive();
        int waited;
        waited = 0;
        while (pwmActive !== 1'b1) begin
            if (waited >= START_TIMEOUT) begin
                $display("Timeout: the motor never started, pwmActive stayed low");
                stopWithFailure();
            end
            tick();
            waited++;
        end
    endtask

    initial begin
        int stepLen;
        int runCycles;
        reset        = 1'b1;
        run          = 1'b0;
        pwmLenWant   = `LEN_W'(16);
        stepSplitMax = 2'd0;
        amplitude    = '0;
        repeat (5) tick();
        reset = 1'b0;
        repeat (4) tick();
        for (int segment = 0; segment < RUN_SEGMENTS; segment++) begin
            pwmLenWant   = `LEN_W'(8 + drawBelow(33));
            stepSplitMax = 2'(drawBelow(4));
            // zero amplitude on the first run must give zero loss
            amplitude    = (segment == 0) ? '0 : `LEN_W'(drawBelow(201));
            repeat (2 + drawBelow(4)) tick();
            run = 1'b1;
            waitActive();
            stepLen   = int'(pwmLenWant) << stepSplitMax;
            runCycles = (2 + drawBelow(2)) * `STEP_COUNT * stepLen + drawBelow(stepLen);
            repeat (runCycles) tick();
            run = 1'b0;
            tick();
        end
        repeat (4) tick();
        $display("No errors");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
motorStepPkg.sv
pwmLoadPkg.sv
stepSequencer.sv
phaseLenTable.sv
pwmPhaseGen.sv
motorPwmTop.sv
motorPwm_props.sv
motorPwmTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module motorPwmTb -f sim.f \
    -o motorPwmSim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/motorPwmSim > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
